//--- verilog/dispatch_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// size constants for the dispatch stage, shared by packages and modules
// NUM_EX_UNITS must match the number of values in ex_type_e
// BUF_SIZE is fixed at two because the unit buffer is built as two slots
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// threads per warp and operand width per thread
`define NUM_THREADS   4
`define XLEN          32

`define NUM_WARPS     4
`define NUM_EX_UNITS  3

// entries in each unit buffer
`define BUF_SIZE      2
`define PERF_CTR_BITS 16

`endif

//--- verilog/isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction encodings seen by dispatch
// ex_type_e values are used directly as unit indices
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

    // execution unit that an instruction targets
    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    // opcodes are carried through dispatch without decoding
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_LOAD  = 4'd4,
        OP_STORE = 4'd5,
        OP_BAR   = 4'd6,
        OP_TMC   = 4'd7
    } op_e;

endpackage

//--- verilog/pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline payload types between operand collection and the units
// widths follow the sizes in dispatch_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "dispatch_cfg.svh"

package pipe_pkg;
    import isa_pkg::*;

    typedef logic [`NUM_THREADS-1:0]         tmask_t;
    typedef logic [$clog2(`NUM_THREADS)-1:0] tid_t;
    typedef logic [$clog2(`NUM_WARPS)-1:0]   wid_t;

    // one XLEN word per thread, thread 0 in the low bits
    typedef logic [`NUM_THREADS-1:0][`XLEN-1:0] lane_data_t;

    // payload held in each unit buffer
    typedef struct packed {
        wid_t       wid;
        tmask_t     tmask;
        op_e        op;
        lane_data_t rs1_data;
        lane_data_t rs2_data;
        tid_t       last_tid;
    } dispatch_data_t;

endpackage

//--- verilog/operands_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid/ready link from operand collection into dispatch
// payload must stay stable while valid is high and ready is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface operands_if import isa_pkg::*, pipe_pkg::*; ();
    logic       valid;
    logic       ready;
    ex_type_e   ex_type;
    wid_t       wid;
    tmask_t     tmask;
    op_e        op;
    lane_data_t rs1_data;
    lane_data_t rs2_data;

    modport master (output valid, ex_type, wid, tmask, op, rs1_data, rs2_data,
                    input  ready);

    modport slave  (input  valid, ex_type, wid, tmask, op, rs1_data, rs2_data,
                    output ready);
endinterface

//--- verilog/dispatch_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid/ready link from dispatch to a single execution unit
// last_tid is the highest active thread, zero for an empty mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface dispatch_if import isa_pkg::*, pipe_pkg::*; ();
    logic       valid;
    logic       ready;
    wid_t       wid;
    tmask_t     tmask;
    op_e        op;
    lane_data_t rs1_data;
    lane_data_t rs2_data;
    tid_t       last_tid;

    modport master (output valid, wid, tmask, op, rs1_data, rs2_data, last_tid,
                    input  ready);

    modport slave  (input  valid, wid, tmask, op, rs1_data, rs2_data, last_tid,
                    output ready);
endinterface

//--- verilog/elastic_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-entry valid/ready buffer with a registered output slot
// ready_in depends only on occupancy, never on ready_out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dispatch_cfg.svh"

module elastic_buffer import pipe_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           valid_in,
    output logic           ready_in,
    input  dispatch_data_t data_in,
    output logic           valid_out,
    input  logic           ready_out,
    output dispatch_data_t data_out
);
    logic           out_valid;
    dispatch_data_t out_data;
    logic           skid_valid;
    dispatch_data_t skid_data;
    logic [1:0]     count;
    logic           push;
    logic           out_free;

    assign count    = {1'b0, out_valid} + {1'b0, skid_valid};
    assign ready_in = (count < 2'(`BUF_SIZE));
    assign push     = valid_in && ready_in;

    // output slot can take a new entry when empty or being consumed
    assign out_free = !out_valid || ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // the skid entry is older, so it moves first
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= push;
            end else begin
                out_valid  <= push;
            end
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (push) begin
                out_data <= data_in;
            end
        end
        // skid_valid decides whether this copy is ever seen
        if (push) begin
            skid_data <= data_in;
        end
    end

    assign valid_out = out_valid;
    assign data_out  = out_data;

endmodule

//--- verilog/dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// routes each instruction to the buffer of the unit named by ex_type
// an out of range ex_type is never accepted
// a stalled unit blocks only instructions that target it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dispatch_cfg.svh"

module dispatch import isa_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    operands_if.slave  operands,
    dispatch_if.master units [`NUM_EX_UNITS]
);
    tid_t                    last_tid;
    dispatch_data_t          buf_in;
    logic [`NUM_EX_UNITS-1:0] buf_ready;
    logic [`NUM_EX_UNITS-1:0] buf_valid;
    dispatch_data_t          buf_out [`NUM_EX_UNITS];

    // highest set bit of the mask, later threads override earlier ones
    always_comb begin
        last_tid = '0;
        for (int t = 0; t < `NUM_THREADS; t++) begin
            if (operands.tmask[t]) begin
                last_tid = tid_t'(t);
            end
        end
    end

    always_comb begin
        buf_in.wid      = operands.wid;
        buf_in.tmask    = operands.tmask;
        buf_in.op       = operands.op;
        buf_in.rs1_data = operands.rs1_data;
        buf_in.rs2_data = operands.rs2_data;
        buf_in.last_tid = last_tid;
    end

    for (genvar i = 0; i < `NUM_EX_UNITS; i++) begin : g_unit
        logic sel;

        assign sel = operands.valid && (operands.ex_type == ex_type_e'(i));

        elastic_buffer u_buffer (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (sel),
            .ready_in  (buf_ready[i]),
            .data_in   (buf_in),
            .valid_out (buf_valid[i]),
            .ready_out (units[i].ready),
            .data_out  (buf_out[i])
        );

        assign units[i].valid    = buf_valid[i];
        assign units[i].wid      = buf_out[i].wid;
        assign units[i].tmask    = buf_out[i].tmask;
        assign units[i].op       = buf_out[i].op;
        assign units[i].rs1_data = buf_out[i].rs1_data;
        assign units[i].rs2_data = buf_out[i].rs2_data;
        assign units[i].last_tid = buf_out[i].last_tid;
    end

    // input ready follows the selected buffer only
    always_comb begin
        operands.ready = 1'b0;
        for (int u = 0; u < `NUM_EX_UNITS; u++) begin
            if (operands.ex_type == ex_type_e'(u)) begin
                operands.ready = buf_ready[u];
            end
        end
    end

endmodule

//--- verilog/stall_counters.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-unit stall cycle counters, wrapping at PERF_CTR_BITS
// a stall shows in its counter two edges after the stalled cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dispatch_cfg.svh"

module stall_counters import isa_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  logic                      in_ready,
    input  ex_type_e                  in_ex_type,
    output logic [`PERF_CTR_BITS-1:0] perf_stalls [`NUM_EX_UNITS]
);
    logic [`NUM_EX_UNITS-1:0] stall_now;
    logic [`NUM_EX_UNITS-1:0] stall_r;

    // one-hot by unit when an offered instruction is refused
    always_comb begin
        stall_now = '0;
        for (int u = 0; u < `NUM_EX_UNITS; u++) begin
            if (in_valid && !in_ready && (in_ex_type == ex_type_e'(u))) begin
                stall_now[u] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_r <= '0;
        end else begin
            stall_r <= stall_now;
        end
    end

    for (genvar i = 0; i < `NUM_EX_UNITS; i++) begin : g_ctr
        always_ff @(posedge clk) begin
            if (reset) begin
                perf_stalls[i] <= '0;
            end else begin
                perf_stalls[i] <= perf_stalls[i] + `PERF_CTR_BITS'(stall_r[i]);
            end
        end
    end

endmodule

//--- verilog/dispatch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatch stage top level with plain ports, arrays indexed by ex_type
// one cycle from input acceptance to out_valid when the unit is idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dispatch_cfg.svh"

module dispatch_top import isa_pkg::*, pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  ex_type_e                  in_ex_type,
    input  wid_t                      in_wid,
    input  tmask_t                    in_tmask,
    input  op_e                       in_op,
    input  lane_data_t                in_rs1_data,
    input  lane_data_t                in_rs2_data,
    output logic [`NUM_EX_UNITS-1:0]  out_valid,
    input  logic [`NUM_EX_UNITS-1:0]  out_ready,
    output wid_t                      out_wid [`NUM_EX_UNITS],
    output tmask_t                    out_tmask [`NUM_EX_UNITS],
    output op_e                       out_op [`NUM_EX_UNITS],
    output lane_data_t                out_rs1_data [`NUM_EX_UNITS],
    output lane_data_t                out_rs2_data [`NUM_EX_UNITS],
    output tid_t                      out_last_tid [`NUM_EX_UNITS],
    output logic [`PERF_CTR_BITS-1:0] perf_stalls [`NUM_EX_UNITS]
);
    operands_if op_if ();
    dispatch_if unit_if [`NUM_EX_UNITS] ();

    assign op_if.valid    = in_valid;
    assign op_if.ex_type  = in_ex_type;
    assign op_if.wid      = in_wid;
    assign op_if.tmask    = in_tmask;
    assign op_if.op       = in_op;
    assign op_if.rs1_data = in_rs1_data;
    assign op_if.rs2_data = in_rs2_data;
    assign in_ready       = op_if.ready;

    for (genvar i = 0; i < `NUM_EX_UNITS; i++) begin : g_out
        assign out_valid[i]    = unit_if[i].valid;
        assign out_wid[i]      = unit_if[i].wid;
        assign out_tmask[i]    = unit_if[i].tmask;
        assign out_op[i]       = unit_if[i].op;
        assign out_rs1_data[i] = unit_if[i].rs1_data;
        assign out_rs2_data[i] = unit_if[i].rs2_data;
        assign out_last_tid[i] = unit_if[i].last_tid;
        assign unit_if[i].ready = out_ready[i];
    end

    dispatch u_dispatch (
        .clk      (clk),
        .reset    (reset),
        .operands (op_if),
        .units    (unit_if)
    );

    // counters watch the input handshake, not the unit side
    stall_counters u_stall_counters (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (op_if.ready),
        .in_ex_type  (in_ex_type),
        .perf_stalls (perf_stalls)
    );

endmodule

//--- testbench/dispatch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table-driven testbench for dispatch_top where out_ready stands in for the units
// the scoreboard samples on the falling edge and keeps one queue per unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dispatch_cfg.svh"

module dispatch_tb import isa_pkg::*, pipe_pkg::*;;
    typedef enum int {RDY_KEEP, RDY_ON, RDY_BLOCK, RDY_RAND} rdy_mode_e;

    // the ready pattern of a row applies to the unit that the row targets
    typedef struct {
        ex_type_e   ex_type;
        wid_t       wid;
        tmask_t     tmask;
        op_e        op;
        lane_data_t rs1;
        lane_data_t rs2;
        rdy_mode_e  mode;
        int         hold;
    } row_t;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    logic                      in_ready;
    ex_type_e                  in_ex_type;
    wid_t                      in_wid;
    tmask_t                    in_tmask;
    op_e                       in_op;
    lane_data_t                in_rs1_data;
    lane_data_t                in_rs2_data;
    logic [`NUM_EX_UNITS-1:0]  out_valid;
    logic [`NUM_EX_UNITS-1:0]  out_ready = '1;
    wid_t                      out_wid [`NUM_EX_UNITS];
    tmask_t                    out_tmask [`NUM_EX_UNITS];
    op_e                       out_op [`NUM_EX_UNITS];
    lane_data_t                out_rs1_data [`NUM_EX_UNITS];
    lane_data_t                out_rs2_data [`NUM_EX_UNITS];
    tid_t                      out_last_tid [`NUM_EX_UNITS];
    logic [`PERF_CTR_BITS-1:0] perf_stalls [`NUM_EX_UNITS];

    row_t           rows [$];
    dispatch_data_t exp_q [`NUM_EX_UNITS][$];
    rdy_mode_e      unit_mode [`NUM_EX_UNITS] = '{default: RDY_ON};
    int             block_until [`NUM_EX_UNITS] = '{default: 0};
    int             stall_cnt [`NUM_EX_UNITS] = '{default: 0};
    int             cycles = 0;
    int             err_scoreboard = 0;
    int             err_checks = 0;

    dispatch_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // scan from the top lane down so the first set bit wins
    function automatic tid_t highest_lane(input tmask_t mask);
        tid_t idx;
        bit   found;
        idx = '0;
        found = 1'b0;
        for (int t = `NUM_THREADS - 1; t >= 0; t--) begin
            if (!found && mask[t]) begin
                idx = tid_t'(t);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    task automatic add_row(input ex_type_e ex, input wid_t wid, input tmask_t tmask,
                           input op_e op, input logic [31:0] seed1, input logic [31:0] seed2,
                           input rdy_mode_e mode, input int hold);
        row_t row;
        row.ex_type = ex;
        row.wid = wid;
        row.tmask = tmask;
        row.op = op;
        row.mode = mode;
        row.hold = hold;
        for (int t = 0; t < `NUM_THREADS; t++) begin
            row.rs1[t] = seed1 ^ $urandom();
            row.rs2[t] = seed2 ^ $urandom();
        end
        rows.push_back(row);
    endtask

    task automatic apply_ready_pattern(input row_t row);
        int u;
        u = int'(row.ex_type);
        case (row.mode)
            RDY_ON:    unit_mode[u] = RDY_ON;
            RDY_RAND:  unit_mode[u] = RDY_RAND;
            RDY_BLOCK: block_until[u] = cycles + row.hold;
            default:   ;
        endcase
    endtask

    function automatic int pending_total();
        int n;
        n = 0;
        for (int u = 0; u < `NUM_EX_UNITS; u++) begin
            n += exp_q[u].size();
        end
        return n;
    endfunction

    task automatic finish_run(input bit timed_out);
        $display("Error counts: scoreboard %0d, reset and counter checks %0d",
                 err_scoreboard, err_checks);
        if (timed_out || err_scoreboard != 0 || err_checks != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    endtask

    // unit ready patterns, cycle count and watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        for (int u = 0; u < `NUM_EX_UNITS; u++) begin
            if (cycles < block_until[u]) begin
                out_ready[u] <= 1'b0;
            end else if (unit_mode[u] == RDY_RAND) begin
                out_ready[u] <= 1'($urandom() % 2);
            end else begin
                out_ready[u] <= 1'b1;
            end
        end
        if (cycles >= rows.size() * 20 + 200) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            finish_run(1'b1);
        end
    end

    // a unit holds exactly the accepted but not yet taken items, so out_valid
    // and in_ready both follow from the queue depth seen before this edge
    always @(negedge clk) begin
        dispatch_data_t got;
        dispatch_data_t exp;
        dispatch_data_t accepted;
        int             u;
        if (!reset) begin
            for (int k = 0; k < `NUM_EX_UNITS; k++) begin
                if (out_valid[k] !== (exp_q[k].size() != 0)) begin
                    $display("Mismatch at %0t: unit %0d out_valid %0b with %0d items pending",
                             $time, k, out_valid[k], exp_q[k].size());
                    err_scoreboard++;
                end
            end
            u = int'(in_ex_type);
            if (in_valid && in_ready !== (exp_q[u].size() < `BUF_SIZE)) begin
                $display("Mismatch at %0t: in_ready %0b for unit %0d holding %0d items",
                         $time, in_ready, u, exp_q[u].size());
                err_scoreboard++;
            end
            for (int k = 0; k < `NUM_EX_UNITS; k++) begin
                if (out_valid[k] && out_ready[k] && exp_q[k].size() != 0) begin
                    got = '{wid: out_wid[k], tmask: out_tmask[k], op: out_op[k],
                            rs1_data: out_rs1_data[k], rs2_data: out_rs2_data[k],
                            last_tid: out_last_tid[k]};
                    exp = exp_q[k].pop_front();
                    if (got !== exp) begin
                        $display("Mismatch at %0t: unit %0d payload %h expected %h",
                                 $time, k, got, exp);
                        err_scoreboard++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                accepted = '{wid: in_wid, tmask: in_tmask, op: in_op,
                             rs1_data: in_rs1_data, rs2_data: in_rs2_data,
                             last_tid: highest_lane(in_tmask)};
                exp_q[u].push_back(accepted);
            end else if (in_valid) begin
                stall_cnt[u]++;
            end
        end
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_ex_type = EX_ALU;
        in_wid = '0;
        in_tmask = '0;
        in_op = OP_ADD;
        in_rs1_data = '0;
        in_rs2_data = '0;
        void'($urandom(37));
        // single-lane, full and empty masks, back-to-back ALU, a blocked LSU and SFU
        add_row(EX_ALU, 2'd0, 4'b0001, OP_ADD,   32'h1001, 32'h2001, RDY_ON,    0);
        add_row(EX_ALU, 2'd1, 4'b0010, OP_SUB,   32'h1002, 32'h2002, RDY_KEEP,  0);
        add_row(EX_ALU, 2'd2, 4'b0100, OP_AND,   32'h1003, 32'h2003, RDY_KEEP,  0);
        add_row(EX_ALU, 2'd3, 4'b1000, OP_OR,    32'h1004, 32'h2004, RDY_KEEP,  0);
        add_row(EX_LSU, 2'd0, 4'b1111, OP_LOAD,  32'h1005, 32'h2005, RDY_BLOCK, 12);
        add_row(EX_LSU, 2'd1, 4'b0000, OP_STORE, 32'h1006, 32'h2006, RDY_KEEP,  0);
        add_row(EX_ALU, 2'd2, 4'b0011, OP_ADD,   32'h1007, 32'h2007, RDY_KEEP,  0);
        add_row(EX_LSU, 2'd2, 4'b0101, OP_LOAD,  32'h1008, 32'h2008, RDY_KEEP,  0);
        add_row(EX_SFU, 2'd3, 4'b1000, OP_BAR,   32'h1009, 32'h2009, RDY_ON,    0);
        add_row(EX_SFU, 2'd0, 4'b0110, OP_TMC,   32'h100a, 32'h200a, RDY_RAND,  0);
        add_row(EX_ALU, 2'd1, 4'b1110, OP_SUB,   32'h100b, 32'h200b, RDY_RAND,  0);
        add_row(EX_LSU, 2'd3, 4'b1001, OP_STORE, 32'h100c, 32'h200c, RDY_RAND,  0);
        add_row(EX_SFU, 2'd1, 4'b0001, OP_BAR,   32'h100d, 32'h200d, RDY_KEEP,  0);
        add_row(EX_ALU, 2'd0, 4'b1010, OP_OR,    32'h100e, 32'h200e, RDY_KEEP,  0);
        add_row(EX_LSU, 2'd2, 4'b0100, OP_LOAD,  32'h100f, 32'h200f, RDY_KEEP,  0);
        add_row(EX_SFU, 2'd3, 4'b1111, OP_TMC,   32'h1010, 32'h2010, RDY_BLOCK, 8);
        add_row(EX_SFU, 2'd2, 4'b0010, OP_BAR,   32'h1011, 32'h2011, RDY_KEEP,  0);
        add_row(EX_SFU, 2'd1, 4'b0000, OP_TMC,   32'h1012, 32'h2012, RDY_KEEP,  0);
        add_row(EX_ALU, 2'd3, 4'b1111, OP_AND,   32'h1013, 32'h2013, RDY_ON,    0);
        add_row(EX_LSU, 2'd0, 4'b1000, OP_STORE, 32'h1014, 32'h2014, RDY_ON,    0);
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        for (int u = 0; u < `NUM_EX_UNITS; u++) begin
            if (out_valid[u] !== 1'b0 || perf_stalls[u] !== '0 || in_ready !== 1'b1) begin
                $display("Mismatch at %0t: reset state unit %0d valid %0b stalls %0d ready %0b",
                         $time, u, out_valid[u], perf_stalls[u], in_ready);
                err_checks++;
            end
        end
        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_ex_type <= rows[r].ex_type;
            in_wid <= rows[r].wid;
            in_tmask <= rows[r].tmask;
            in_op <= rows[r].op;
            in_rs1_data <= rows[r].rs1;
            in_rs2_data <= rows[r].rs2;
            @(negedge clk);
            apply_ready_pattern(rows[r]);
            while (!in_ready) @(negedge clk);
        end
        unit_mode = '{default: RDY_ON};
        @(posedge clk);
        in_valid <= 1'b0;
        while (pending_total() != 0) @(posedge clk);
        // the counters lag the stalled cycle by two edges
        repeat (2) @(posedge clk);
        @(negedge clk);
        for (int u = 0; u < `NUM_EX_UNITS; u++) begin
            if (perf_stalls[u] !== `PERF_CTR_BITS'(stall_cnt[u])) begin
                $display("Mismatch at %0t: unit %0d perf_stalls %0d, expected %0d",
                         $time, u, perf_stalls[u], stall_cnt[u]);
                err_checks++;
            end
        end
        finish_run(1'b0);
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/operands_if.sv
verilog/dispatch_if.sv
verilog/elastic_buffer.sv
verilog/dispatch.sv
verilog/stall_counters.sv
verilog/dispatch_top.sv
testbench/dispatch_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the dispatch testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module dispatch_tb \
    --Mdir obj_dir -o dispatch_tb_sim

./obj_dir/dispatch_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    echo "run_sim.sh: pass message not found in sim.log"
    exit 1
fi
